// ==== ps2_mouse_pkg.sv ====
/*
 * PS/2 mouse cursor package with screen limits, frame and packet sizes, shared structs
 */
`default_nettype none

package ps2_mouse_pkg;

	// Datapath widths
	localparam int CURSOR_W = 10;
	localparam int MOVE_W = 8;
	// One bit more than a byte so that 256 fits
	localparam int MAG_W = 9;

	// Screen limits, 5 pixel margin on a 640x480 screen
	localparam logic [CURSOR_W-1:0] SCREEN_MIN = 10'd5;
	localparam logic [CURSOR_W-1:0] X_MAX = 10'd635;
	localparam logic [CURSOR_W-1:0] Y_MAX = 10'd475;
	localparam logic [CURSOR_W-1:0] X_RESET = 10'd320;
	localparam logic [CURSOR_W-1:0] Y_RESET = 10'd240;

	// Frame and packet framing
	localparam int FRAME_DATA_BITS = 8;
	localparam int PACKET_BYTES = 3;
	localparam int BIT_CNT_W = $clog2(FRAME_DATA_BITS);
	localparam int BYTE_CNT_W = $clog2(PACKET_BYTES);

	// Synchronized PS/2 lines, data aligned with the clock edge pulse
	typedef struct packed {
		logic data;
		logic clk_rise;
	} ps2_line_t;

	// One movement packet in standard byte order
	typedef struct packed {
		logic left;
		logic right;
		logic middle;
		logic x_sign;
		logic y_sign;
		logic [MOVE_W-1:0] dx;
		logic [MOVE_W-1:0] dy;
	} mouse_packet_t;

	// Cursor position and button levels
	typedef struct packed {
		logic [CURSOR_W-1:0] x;
		logic [CURSOR_W-1:0] y;
		logic left;
		logic middle;
		logic right;
	} cursor_t;

endpackage

`default_nettype wire

// ==== ps2_line_sync.sv ====
/*
 * PS/2 line synchronizer, two flops per line plus registered clock rising edge
 */
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync
	import ps2_mouse_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic ps2_clk,
	input  wire logic ps2_dat,
	output ps2_line_t line
);

	logic clk_s1;
	logic clk_s2;
	logic clk_prev;
	logic dat_s1;
	logic dat_s2;

	always_ff @(posedge clk)
	begin
		// Idle bus is high on both lines
		if (reset)
		begin
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			clk_prev <= 1'b1;
			dat_s1 <= 1'b1;
			dat_s2 <= 1'b1;
			line.data <= 1'b1;
			line.clk_rise <= 1'b0;
		end
		else
		begin
			clk_s1 <= ps2_clk;
			clk_s2 <= clk_s1;
			// Previous clock level for edge detection
			clk_prev <= clk_s2;
			dat_s1 <= ps2_dat;
			dat_s2 <= dat_s1;
			// Third stage, so data and edge leave together
			line.data <= dat_s2;
			line.clk_rise <= clk_s2 & ~clk_prev;
		end
	end

endmodule

`default_nettype wire

// ==== ps2_frame_rx.sv ====
/*
 * PS/2 frame receiver, shifts in start, 8 data bits, parity and stop, strobes the byte
 */
`timescale 1ns/10ps
`default_nettype none

module ps2_frame_rx
	import ps2_mouse_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire ps2_line_t line,
	output logic [MOVE_W-1:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} rx_state_t;

	rx_state_t state;
	rx_state_t state_next;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [MOVE_W-1:0] shift_reg;

	// Next state, every move waits for a clock rising edge
	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
			begin
				// Start bit is a low data level
				if (line.clk_rise && !line.data)
					state_next = ST_DATA;
			end
			ST_DATA:
			begin
				if (line.clk_rise && bit_cnt == BIT_CNT_W'(FRAME_DATA_BITS - 1))
					state_next = ST_PARITY;
			end
			ST_PARITY:
			begin
				// Parity bit sampled but not checked
				if (line.clk_rise)
					state_next = ST_STOP;
			end
			ST_STOP:
			begin
				if (line.clk_rise)
					state_next = ST_IDLE;
			end
			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			state <= state_next;
			rx_valid <= (state == ST_STOP) && line.clk_rise;
			// Bit counter only runs while data bits come in
			if (state != ST_DATA)
				bit_cnt <= '0;
			else if (line.clk_rise)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// LSB first, so new bits enter at the top
	always_ff @(posedge clk)
	begin
		if (state == ST_DATA && line.clk_rise)
			shift_reg <= {line.data, shift_reg[MOVE_W-1:1]};
		if (state == ST_STOP && line.clk_rise)
			rx_byte <= shift_reg;
	end

	// A frame is 11 PS/2 clocks long, so strobes never touch
	a_rx_valid_single: assert property (@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== mouse_packet_asm.sv ====
/*
 * Mouse packet assembler, groups status, dx and dy bytes into one packet strobe
 */
`timescale 1ns/10ps
`default_nettype none

module mouse_packet_asm
	import ps2_mouse_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic [MOVE_W-1:0] rx_byte,
	input  wire logic rx_valid,
	output mouse_packet_t packet,
	output logic packet_valid
);

	logic [BYTE_CNT_W-1:0] byte_cnt;
	// Status byte fields and dx held until dy arrives
	logic [4:0] status_q;
	logic [MOVE_W-1:0] dx_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			byte_cnt <= '0;
			packet_valid <= 1'b0;
		end
		else
		begin
			packet_valid <= rx_valid && byte_cnt == BYTE_CNT_W'(PACKET_BYTES - 1);
			if (rx_valid)
			begin
				if (byte_cnt == BYTE_CNT_W'(PACKET_BYTES - 1))
					byte_cnt <= '0;
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_valid)
		begin
			case (byte_cnt)
				// Buttons in bits 2..0, signs in bits 5..4
				2'd0: status_q <= {rx_byte[5:4], rx_byte[2:0]};
				2'd1: dx_q <= rx_byte;
				default:
				begin
					// Whole packet published at once
					packet.y_sign <= status_q[4];
					packet.x_sign <= status_q[3];
					packet.middle <= status_q[2];
					packet.right <= status_q[1];
					packet.left <= status_q[0];
					packet.dx <= dx_q;
					packet.dy <= rx_byte;
				end
			endcase
		end
	end

	a_byte_cnt_range: assert property (@(posedge clk) disable iff (reset)
		byte_cnt < BYTE_CNT_W'(PACKET_BYTES));

endmodule

`default_nettype wire

// ==== cursor_tracker.sv ====
/*
 * Cursor tracker, applies signed packet movement with clamping and holds buttons
 */
`timescale 1ns/10ps
`default_nettype none

module cursor_tracker
	import ps2_mouse_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire mouse_packet_t packet,
	input  wire logic packet_valid,
	output cursor_t cursor
);

	logic [MAG_W-1:0] mag_x;
	logic [MAG_W-1:0] mag_y;

	// Move one coordinate by a magnitude and clamp to SCREEN_MIN..hi
	function automatic logic [CURSOR_W-1:0] step(
		input logic [CURSOR_W-1:0] pos,
		input logic [MAG_W-1:0] mag,
		input logic sub,
		input logic [CURSOR_W-1:0] hi
	);
		logic [CURSOR_W:0] wide_pos;
		logic [CURSOR_W:0] wide_mag;
		logic [CURSOR_W:0] sum;
		wide_pos = {1'b0, pos};
		wide_mag = {{(CURSOR_W + 1 - MAG_W){1'b0}}, mag};
		sum = wide_pos + wide_mag;
		if (sub)
		begin
			// Compare before subtracting to avoid wrap below zero
			if (wide_pos < wide_mag + {1'b0, SCREEN_MIN})
				step = SCREEN_MIN;
			else
				step = CURSOR_W'(wide_pos - wide_mag);
		end
		else
		begin
			if (sum > {1'b0, hi})
				step = hi;
			else
				step = CURSOR_W'(sum);
		end
	endfunction

	// Magnitude of a signed byte, 0x00 with sign set gives 256
	assign mag_x = packet.x_sign ? {1'b0, ~packet.dx} + 1'b1 : {1'b0, packet.dx};
	assign mag_y = packet.y_sign ? {1'b0, ~packet.dy} + 1'b1 : {1'b0, packet.dy};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cursor.x <= X_RESET;
			cursor.y <= Y_RESET;
			cursor.left <= 1'b0;
			cursor.middle <= 1'b0;
			cursor.right <= 1'b0;
		end
		else if (packet_valid)
		begin
			cursor.x <= step(cursor.x, mag_x, packet.x_sign, X_MAX);
			// Screen Y grows downward, so the sign is inverted
			cursor.y <= step(cursor.y, mag_y, !packet.y_sign, Y_MAX);
			cursor.left <= packet.left;
			cursor.middle <= packet.middle;
			cursor.right <= packet.right;
		end
	end

	a_cursor_in_bounds: assert property (@(posedge clk) disable iff (reset)
		cursor.x >= SCREEN_MIN && cursor.x <= X_MAX &&
		cursor.y >= SCREEN_MIN && cursor.y <= Y_MAX);

endmodule

`default_nettype wire

// ==== ps2_mouse.sv ====
/*
 * PS/2 mouse top, line sync, frame receiver, packet assembler and cursor tracker
 */
`timescale 1ns/10ps
`default_nettype none

module ps2_mouse
	import ps2_mouse_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic ps2_clk,
	input  wire logic ps2_dat,
	output cursor_t cursor,
	output logic packet_valid
);

	ps2_line_t line;
	logic [MOVE_W-1:0] rx_byte;
	logic rx_valid;
	mouse_packet_t packet;

	// Synchronized lines and clock edge
	ps2_line_sync u_ps2_line_sync (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_dat(ps2_dat),
		.line(line)
	);

	ps2_frame_rx u_ps2_frame_rx (
		.clk(clk),
		.reset(reset),
		.line(line),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	// Three bytes per packet
	mouse_packet_asm u_mouse_packet_asm (
		.clk(clk),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.packet(packet),
		.packet_valid(packet_valid)
	);

	cursor_tracker u_cursor_tracker (
		.clk(clk),
		.reset(reset),
		.packet(packet),
		.packet_valid(packet_valid),
		.cursor(cursor)
	);

endmodule

`default_nettype wire

// ==== tb_ps2_mouse.sv ====
/*
 * PS/2 mouse testbench, sends packet table as PS/2 frames and checks the cursor
 */
`timescale 1ns/10ps
`default_nettype none

module tb_ps2_mouse
	import ps2_mouse_pkg::*;
();

	localparam int NUM_ROWS = 13;
	// PS/2 half period in clk cycles
	localparam int HALF = 8;
	localparam int SETTLE = 10;
	localparam int MAX_GAP = 20;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 3 * 11 * 16 + NUM_ROWS * 40 + 200;
	localparam logic [31:0] SEED = 32'hd0fe2e3a;

	// One table row, packet bytes and the cursor expected after it
	typedef struct packed {
		logic [7:0] status;
		logic [7:0] dx;
		logic [7:0] dy;
		cursor_t exp_cur;
	} row_t;

	logic clk;
	logic reset;
	logic ps2_clk;
	logic ps2_dat;
	cursor_t cursor;
	logic packet_valid;

	row_t rows [NUM_ROWS];
	int err_cnt;
	int pulse_cnt;
	int cycle_cnt;

	ps2_mouse u_ps2_mouse (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_dat(ps2_dat),
		.cursor(cursor),
		.packet_valid(packet_valid)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// Row built from bytes and hand computed cursor
	function automatic row_t make_row(
		input logic [7:0] status,
		input logic [7:0] dx,
		input logic [7:0] dy,
		input logic [CURSOR_W-1:0] x,
		input logic [CURSOR_W-1:0] y,
		input logic left,
		input logic middle,
		input logic right
	);
		row_t r;
		r.status = status;
		r.dx = dx;
		r.dy = dy;
		r.exp_cur.x = x;
		r.exp_cur.y = y;
		r.exp_cur.left = left;
		r.exp_cur.middle = middle;
		r.exp_cur.right = right;
		return r;
	endfunction

	// One frame, start, data LSB first, odd parity, stop
	// Data changes with the falling PS/2 clock, DUT samples on the rise
	task automatic send_frame(input logic [7:0] data);
		logic [10:0] bits;
		bits = {1'b1, ~^data, data, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			ps2_clk <= 1'b0;
			ps2_dat <= bits[i];
			repeat (HALF) @(posedge clk);
			ps2_clk <= 1'b1;
			// Caller owns the time after the stop bit rise
			if (i < 10)
				repeat (HALF) @(posedge clk);
		end
	endtask

	task automatic check_cursor(input cursor_t exp, input string where);
		if (cursor.x !== exp.x)
		begin
			$display("** Error: cursor.x expected %h actual %h, %s", exp.x, cursor.x, where);
			err_cnt++;
		end
		if (cursor.y !== exp.y)
		begin
			$display("** Error: cursor.y expected %h actual %h, %s", exp.y, cursor.y, where);
			err_cnt++;
		end
		if (cursor.left !== exp.left)
		begin
			$display("** Error: cursor.left expected %h actual %h, %s",
				exp.left, cursor.left, where);
			err_cnt++;
		end
		if (cursor.middle !== exp.middle)
		begin
			$display("** Error: cursor.middle expected %h actual %h, %s",
				exp.middle, cursor.middle, where);
			err_cnt++;
		end
		if (cursor.right !== exp.right)
		begin
			$display("** Error: cursor.right expected %h actual %h, %s",
				exp.right, cursor.right, where);
			err_cnt++;
		end
	endtask

	// Pulse count over the whole run
	always @(posedge clk)
	begin
		if (!reset && packet_valid)
			pulse_cnt++;
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES)
		begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	initial
	begin
		cursor_t last_exp;
		int gap;
		// Idle bus, reset held
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		err_cnt = 0;
		pulse_cnt = 0;
		cycle_cnt = 0;
		void'($urandom(SEED));

		// Start at (320, 240), signs and buttons in status byte
		rows[0] = make_row(8'h08, 8'h0A, 8'h0A, 10'd330, 10'd230, 1'b0, 1'b0, 1'b0);
		rows[1] = make_row(8'h38, 8'hF6, 8'hF6, 10'd320, 10'd240, 1'b0, 1'b0, 1'b0);
		rows[2] = make_row(8'h09, 8'h7F, 8'h00, 10'd447, 10'd240, 1'b1, 1'b0, 1'b0);
		rows[3] = make_row(8'h0A, 8'h7F, 8'h7F, 10'd574, 10'd113, 1'b0, 1'b0, 1'b1);
		// Clamp at right and top edges
		rows[4] = make_row(8'h0C, 8'h7F, 8'h7F, 10'd635, 10'd5, 1'b0, 1'b1, 1'b0);
		rows[5] = make_row(8'h08, 8'h01, 8'h01, 10'd635, 10'd5, 1'b0, 1'b0, 1'b0);
		// Magnitude 256 on X
		rows[6] = make_row(8'h18, 8'h00, 8'h00, 10'd379, 10'd5, 1'b0, 1'b0, 1'b0);
		rows[7] = make_row(8'h1F, 8'h00, 8'h00, 10'd123, 10'd5, 1'b1, 1'b1, 1'b1);
		rows[8] = make_row(8'h18, 8'h00, 8'h00, 10'd5, 10'd5, 1'b0, 1'b0, 1'b0);
		// Magnitude 256 on Y, then bottom clamp
		rows[9] = make_row(8'h28, 8'h00, 8'h00, 10'd5, 10'd261, 1'b0, 1'b0, 1'b0);
		rows[10] = make_row(8'h28, 8'h00, 8'h00, 10'd5, 10'd475, 1'b0, 1'b0, 1'b0);
		rows[11] = make_row(8'h2B, 8'h05, 8'hFF, 10'd10, 10'd475, 1'b1, 1'b0, 1'b1);
		rows[12] = make_row(8'h18, 8'hFB, 8'h0A, 10'd5, 10'd465, 1'b0, 1'b0, 1'b0);

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		// Reset state, no packet yet
		last_exp = '{x: X_RESET, y: Y_RESET, left: 1'b0, middle: 1'b0, right: 1'b0};
		check_cursor(last_exp, "after reset");
		if (pulse_cnt != 0)
		begin
			$display("** Error: packet_valid pulses expected %h actual %h, after reset",
				0, pulse_cnt);
			err_cnt++;
		end

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			send_frame(rows[i].status);
			repeat (HALF) @(posedge clk);
			// Partial packet leaves the cursor alone
			check_cursor(last_exp, $sformatf("row %0d after frame 1", i));
			send_frame(rows[i].dx);
			repeat (HALF) @(posedge clk);
			check_cursor(last_exp, $sformatf("row %0d after frame 2", i));
			send_frame(rows[i].dy);
			repeat (SETTLE) @(posedge clk);
			check_cursor(rows[i].exp_cur, $sformatf("row %0d after frame 3", i));
			if (pulse_cnt != i + 1)
			begin
				$display("** Error: packet_valid pulses expected %h actual %h, row %0d",
					i + 1, pulse_cnt, i);
				err_cnt++;
			end
			last_exp = rows[i].exp_cur;
			gap = $urandom % (MAX_GAP + 1);
			repeat (gap) @(posedge clk);
		end

		$display("Errors: %0d, packets: %0d of %0d", err_cnt, pulse_cnt, NUM_ROWS);
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
ps2_mouse_pkg.sv
ps2_line_sync.sv
ps2_frame_rx.sv
mouse_packet_asm.sv
cursor_tracker.sv
ps2_mouse.sv
tb_ps2_mouse.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the PS/2 mouse testbench with Verilator, run it, check the log
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_ps2_mouse -o sim_ps2_mouse \
	&& ./obj_dir/sim_ps2_mouse > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log \
	&& { echo "Simulation failed"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }
